// ==== verilog/demod_pkg.sv ====
`default_nettype none

package demod_pkg;

  // ********************
  // widths and constants
  // ********************
  localparam int ADDR_W        = 12;  // byte address with bit 0 always zero
  localparam int DATA_W        = 16;  // host data word
  localparam int REG_W         = 32;  // full register with addr bit 1 picking the half
  localparam int NUM_DACS      = 3;
  localparam int SCK_DIV       = 4;   // ck933 cycles per serial clock
  localparam int FRAME_BITS    = 16;
  localparam int RESET_STRETCH = 6;   // soft reset length in cycles
  localparam int SYNC_STAGES   = 2;

  localparam logic [DATA_W-1:0] VERSION = 16'h0056;

  // serial engine counters
  localparam int PHASE_W = $clog2(SCK_DIV);
  localparam int CNT_W   = $clog2(FRAME_BITS);
  localparam logic [PHASE_W-1:0] PH_RISE  = PHASE_W'(SCK_DIV / 2 - 1);  // sclk goes high next
  localparam logic [PHASE_W-1:0] PH_LAST  = PHASE_W'(SCK_DIV - 1);
  localparam logic [CNT_W-1:0]   BIT_LAST = CNT_W'(FRAME_BITS - 1);
  localparam logic [CNT_W-1:0]   BIT_TURN = CNT_W'(FRAME_BITS / 2 - 1);  // last instruction bit

  // ********************
  // address map
  // ********************
  typedef enum logic [3:0] {
    SPACE_MISC = 4'h0,
    SPACE_DAC  = 4'h1
  } space_t;  // from addr[11:8] with other codes unmapped

  typedef enum logic [7:0] {
    MISC_RESET   = 8'h00,  // read triggers soft reset
    MISC_VERSION = 8'h04,
    MISC_CLOCK   = 8'h08
  } misc_reg_t;

  typedef enum logic [7:0] {
    DAC_CTRL   = 8'h00,  // [1:0] dac number, [2] read flag
    DAC_FRAME  = 8'h02,
    DAC_STATUS = 8'h04,  // [0] busy
    DAC_RDATA  = 8'h06
  } dac_reg_t;

  typedef enum logic [0:0] {
    ST_IDLE,
    ST_SHIFT
  } dac_state_t;

  // ********************
  // bundles
  // ********************
  typedef struct packed {
    space_t            space;
    logic [7:0]        offset;
    logic              hi_half;
    logic [DATA_W-1:0] wdata;
    logic              wr_stb;
    logic              rd_stb;
    logic              acc_stb;
  } host_req_t;

  typedef struct packed {
    logic                sclk;
    logic [NUM_DACS-1:0] ncs;     // active low
    logic                sdo;
    logic                sdo_oe;
  } dac_pins_t;

  localparam dac_pins_t PINS_IDLE = '{sclk: 1'b0, ncs: '1, sdo: 1'b0, sdo_oe: 1'b0};

endpackage

`default_nettype wire

// ==== verilog/host_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bus (
  input  logic                          ck933,
  input  logic                          clockCounterEn,
  input  logic                          ncs_i,
  input  logic                          nwe_i,
  input  logic                          nrd_i,
  input  logic [demod_pkg::ADDR_W-1:1]  addr_i,
  input  logic [demod_pkg::DATA_W-1:0]  data_i,
  input  logic [demod_pkg::DATA_W-1:0]  misc_rdata_i,
  input  logic [demod_pkg::DATA_W-1:0]  dac_rdata_i,
  output demod_pkg::host_req_t          req_o,
  output logic [demod_pkg::DATA_W-1:0]  data_o,
  output logic                          data_oe_o
);

  logic [demod_pkg::ADDR_W-1:1]      addr_q;
  logic [demod_pkg::ADDR_W-1:0]      addr_full;
  logic [demod_pkg::DATA_W-1:0]      data_q;
  logic [demod_pkg::DATA_W-1:0]      wdata_q;   // data seen while nwe low
  logic [demod_pkg::SYNC_STAGES-1:0] ncs_sync;
  logic [demod_pkg::SYNC_STAGES-1:0] nwe_sync;
  logic [demod_pkg::SYNC_STAGES-1:0] nrd_sync;
  logic                              ncs_s;
  logic                              nwe_s;
  logic                              nrd_s;
  logic                              ncs_d;
  logic                              nwe_d;
  logic                              nrd_d;
  logic                              wr_stb;
  logic                              rd_stb;
  logic                              acc_stb;

  assign ncs_s = ncs_sync[demod_pkg::SYNC_STAGES-1];
  assign nwe_s = nwe_sync[demod_pkg::SYNC_STAGES-1];
  assign nrd_s = nrd_sync[demod_pkg::SYNC_STAGES-1];

  // ********************
  // bus sampling
  // ********************
  always_ff @(posedge ck933) begin
    addr_q <= addr_i;
    data_q <= data_i;
    if (!nwe_sync[0]) begin
      wdata_q <= data_q;  // both lag the pins by one cycle
    end
  end

  // strobes are synchronized, then edge detected into one-cycle pulses
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      ncs_sync <= '1;
      nwe_sync <= '1;
      nrd_sync <= '1;
      ncs_d    <= 1'b1;
      nwe_d    <= 1'b1;
      nrd_d    <= 1'b1;
      wr_stb   <= 1'b0;
      rd_stb   <= 1'b0;
      acc_stb  <= 1'b0;
    end else begin
      ncs_sync <= {ncs_sync[demod_pkg::SYNC_STAGES-2:0], ncs_i};
      nwe_sync <= {nwe_sync[demod_pkg::SYNC_STAGES-2:0], nwe_i};
      nrd_sync <= {nrd_sync[demod_pkg::SYNC_STAGES-2:0], nrd_i};
      ncs_d    <= ncs_s;
      nwe_d    <= nwe_s;
      nrd_d    <= nrd_s;
      wr_stb   <= nwe_s & ~nwe_d & ~ncs_s;  // end of write
      rd_stb   <= ~nrd_s & nrd_d & ~ncs_s;  // start of read
      acc_stb  <= ~ncs_s & ncs_d;
    end
  end

  // ********************
  // decode and read mux
  // ********************
  assign addr_full = {addr_q, 1'b0};

  always_comb begin
    req_o.space   = demod_pkg::space_t'(addr_full[11:8]);
    req_o.offset  = addr_full[7:0];
    req_o.hi_half = addr_full[1];
    req_o.wdata   = wdata_q;
    req_o.wr_stb  = wr_stb;
    req_o.rd_stb  = rd_stb;
    req_o.acc_stb = acc_stb;
  end

  always_comb begin
    case (req_o.space)
      demod_pkg::SPACE_MISC: data_o = misc_rdata_i;
      demod_pkg::SPACE_DAC:  data_o = dac_rdata_i;
      default:               data_o = '0;  // unmapped
    endcase
  end

  assign data_oe_o = ~ncs_s & ~nrd_s;

  // nwe and nrd are never both low in one access
  wr_rd_excl_a: assert property (@(posedge ck933) disable iff (clockCounterEn)
    !(wr_stb && rd_stb));

endmodule

`default_nettype wire

// ==== verilog/misc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module misc_regs (
  input  logic                          ck933,
  input  logic                          clockCounterEn,
  input  demod_pkg::host_req_t          req_i,
  output logic [demod_pkg::DATA_W-1:0]  rdata_o,
  output logic                          soft_rst_o
);

  logic                         misc_sel;
  logic [7:0]                   reg_off;
  logic                         counter_restart;
  logic                         hold_en;
  logic                         rst_trig;
  logic [demod_pkg::REG_W-1:0]  clock_count;
  logic [demod_pkg::REG_W-1:0]  clock_hold;
  logic [demod_pkg::REG_W-1:0]  reg_word;
  logic [2:0]                   stretch_cnt;

  assign misc_sel = (req_i.space == demod_pkg::SPACE_MISC);
  assign reg_off  = {req_i.offset[7:2], 2'b00};  // half bit dropped

  assign counter_restart = misc_sel && req_i.wr_stb && (reg_off == demod_pkg::MISC_CLOCK);
  assign hold_en         = misc_sel && req_i.acc_stb;
  assign rst_trig        = misc_sel && req_i.rd_stb && (reg_off == demod_pkg::MISC_RESET)
                           && !soft_rst_o;

  // ********************
  // clock measurement
  // ********************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      clock_count <= '0;
    end else if (counter_restart) begin
      clock_count <= '0;
    end else begin
      clock_count <= clock_count + 1'b1;
    end
  end

  // snapshot at the start of each access
  always_ff @(posedge ck933) begin
    if (hold_en) begin
      clock_hold <= clock_count;
    end
  end

  // ********************
  // soft reset
  // ********************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      soft_rst_o  <= 1'b0;
      stretch_cnt <= '0;
    end else if (rst_trig) begin
      soft_rst_o  <= 1'b1;
      stretch_cnt <= 3'(demod_pkg::RESET_STRETCH - 1);
    end else if (stretch_cnt != '0) begin
      stretch_cnt <= stretch_cnt - 1'b1;  // hold soft_rst
    end else begin
      soft_rst_o  <= 1'b0;
    end
  end

  // read word
  always_comb begin
    case (demod_pkg::misc_reg_t'(reg_off))
      demod_pkg::MISC_VERSION: reg_word = {demod_pkg::VERSION, 16'h0000};
      demod_pkg::MISC_CLOCK:   reg_word = clock_hold;
      default:                 reg_word = '0;  // reset reg reads zero
    endcase
  end

  assign rdata_o = req_i.hi_half ? reg_word[31:16] : reg_word[15:0];

  // a started soft reset always runs its full length
  stretch_len_a: assert property (@(posedge ck933) disable iff (clockCounterEn)
    $rose(soft_rst_o) |-> soft_rst_o [*demod_pkg::RESET_STRETCH] ##1 !soft_rst_o);

endmodule

`default_nettype wire

// ==== verilog/dac_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_spi_master (
  input  logic                          ck933,
  input  logic                          clockCounterEn,
  input  logic                          soft_rst_i,
  input  demod_pkg::host_req_t          req_i,
  input  logic                          sdio_i,
  output logic [demod_pkg::DATA_W-1:0]  rdata_o,
  output demod_pkg::dac_pins_t          pins_o
);

  demod_pkg::dac_state_t                  state;
  logic [demod_pkg::PHASE_W-1:0]          phase;    // divide by SCK_DIV
  logic [demod_pkg::CNT_W-1:0]            bit_cnt;
  logic [1:0]                             ctrl_num;
  logic                                   ctrl_rd;
  logic [demod_pkg::FRAME_BITS-1:0]       frame_q;
  logic [demod_pkg::FRAME_BITS-1:0]       shift_q;
  logic [7:0]                             rx_shift;
  logic [7:0]                             rdata_q;
  logic [demod_pkg::NUM_DACS-1:0]         cs_mask;
  logic                                   dac_sel;
  logic                                   busy;
  logic                                   wr_ctrl;
  logic                                   start;
  logic                                   shift_en;
  logic                                   sample_en;
  logic                                   done;

  assign dac_sel = (req_i.space == demod_pkg::SPACE_DAC);
  assign busy    = (state == demod_pkg::ST_SHIFT);
  assign wr_ctrl = dac_sel && req_i.wr_stb && (req_i.offset == demod_pkg::DAC_CTRL);

  // chip select pattern for the requested dac and all high if out of range
  always_comb begin
    for (int i = 0; i < demod_pkg::NUM_DACS; i++) begin
      cs_mask[i] = (req_i.wdata[1:0] != 2'(i));
    end
  end

  assign start     = wr_ctrl && !busy && !(&cs_mask);  // dropped while busy
  assign shift_en  = busy && (phase == '0);
  assign sample_en = busy && ctrl_rd && (phase == demod_pkg::PH_RISE)
                     && (bit_cnt > demod_pkg::BIT_TURN);
  assign done      = busy && (phase == demod_pkg::PH_LAST)
                     && (bit_cnt == demod_pkg::BIT_LAST) && !soft_rst_i;

  // ********************
  // host registers
  // ********************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      ctrl_num <= '0;
      ctrl_rd  <= 1'b0;
    end else if (start) begin
      ctrl_num <= req_i.wdata[1:0];
      ctrl_rd  <= req_i.wdata[2];
    end
  end

  always_ff @(posedge ck933) begin
    if (dac_sel && req_i.wr_stb && (req_i.offset == demod_pkg::DAC_FRAME)) begin
      frame_q <= req_i.wdata;
    end
    if (start) begin
      shift_q <= frame_q;
    end else if (shift_en) begin
      shift_q <= {shift_q[demod_pkg::FRAME_BITS-2:0], 1'b0};  // msb first
    end
    if (sample_en) begin
      rx_shift <= {rx_shift[6:0], sdio_i};
    end
    if (done) begin
      rdata_q <= rx_shift;
    end
  end

  always_comb begin
    case (demod_pkg::dac_reg_t'(req_i.offset))
      demod_pkg::DAC_CTRL:   rdata_o = {13'h0000, ctrl_rd, ctrl_num};
      demod_pkg::DAC_FRAME:  rdata_o = frame_q;
      demod_pkg::DAC_STATUS: rdata_o = {15'h0000, busy};
      demod_pkg::DAC_RDATA:  rdata_o = {8'h00, rdata_q};
      default:               rdata_o = '0;
    endcase
  end

  // ********************
  // shift engine
  // ********************
  always_ff @(posedge ck933 or posedge clockCounterEn) begin
    if (clockCounterEn) begin
      state   <= demod_pkg::ST_IDLE;
      phase   <= '0;
      bit_cnt <= '0;
      pins_o  <= demod_pkg::PINS_IDLE;
    end else if (soft_rst_i) begin
      state   <= demod_pkg::ST_IDLE;  // abort any transfer
      phase   <= '0;
      bit_cnt <= '0;
      pins_o  <= demod_pkg::PINS_IDLE;
    end else begin
      case (state)
        demod_pkg::ST_IDLE: begin
          if (start) begin
            state         <= demod_pkg::ST_SHIFT;
            phase         <= '0;
            bit_cnt       <= '0;
            pins_o.ncs    <= cs_mask;
            pins_o.sdo_oe <= 1'b1;
          end
        end
        demod_pkg::ST_SHIFT: begin
          phase <= phase + 1'b1;
          if (shift_en) begin
            pins_o.sdo <= shift_q[demod_pkg::FRAME_BITS-1];  // sclk is low here
          end
          if (phase == demod_pkg::PH_RISE) begin
            pins_o.sclk <= 1'b1;
          end
          if (phase == demod_pkg::PH_LAST) begin
            pins_o.sclk <= 1'b0;
            if (done) begin
              state  <= demod_pkg::ST_IDLE;
              pins_o <= demod_pkg::PINS_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              if (ctrl_rd && (bit_cnt == demod_pkg::BIT_TURN)) begin
                pins_o.sdo_oe <= 1'b0;  // hand the line to the dac
              end
            end
          end
        end
        default: state <= demod_pkg::ST_IDLE;
      endcase
    end
  end

  one_cs_a: assert property (@(posedge ck933) disable iff (clockCounterEn)
    $onehot0(~pins_o.ncs));

  // the data line is only driven toward a selected dac
  oe_needs_cs_a: assert property (@(posedge ck933) disable iff (clockCounterEn)
    pins_o.sdo_oe |-> !(&pins_o.ncs));

endmodule

`default_nettype wire

// ==== verilog/demod_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module demod_top (
  input  logic                                ck933,
  input  logic                                clockCounterEn,
  input  logic                                ncs_i,
  input  logic                                nwe_i,
  input  logic                                nrd_i,
  input  logic [demod_pkg::ADDR_W-1:1]        addr_i,  // addr1 to addr11
  input  logic [demod_pkg::DATA_W-1:0]        data_i,
  output logic [demod_pkg::DATA_W-1:0]        data_o,
  output logic                                data_oe_o,
  input  logic                                dac_sdio_i,
  output logic                                dac_sdio_o,
  output logic                                dac_sdio_oe_o,
  output logic                                dac_sclk_o,
  output logic [demod_pkg::NUM_DACS-1:0]      dac_ncs_o,
  output logic                                dac_rst_o
);

  demod_pkg::host_req_t          req;
  demod_pkg::dac_pins_t          dac_pins;
  logic [demod_pkg::DATA_W-1:0]  misc_rdata;
  logic [demod_pkg::DATA_W-1:0]  dac_rdata;
  logic                          soft_rst;

  host_bus u_host_bus (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .ncs_i          (ncs_i),
    .nwe_i          (nwe_i),
    .nrd_i          (nrd_i),
    .addr_i         (addr_i),
    .data_i         (data_i),
    .misc_rdata_i   (misc_rdata),
    .dac_rdata_i    (dac_rdata),
    .req_o          (req),
    .data_o         (data_o),
    .data_oe_o      (data_oe_o)
  );

  misc_regs u_misc_regs (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .req_i          (req),
    .rdata_o        (misc_rdata),
    .soft_rst_o     (soft_rst)
  );

  dac_spi_master u_dac_spi (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .soft_rst_i     (soft_rst),
    .req_i          (req),
    .sdio_i         (dac_sdio_i),
    .rdata_o        (dac_rdata),
    .pins_o         (dac_pins)
  );

  // sclk is shared by all three dacs
  assign dac_sclk_o    = dac_pins.sclk;
  assign dac_ncs_o     = dac_pins.ncs;
  assign dac_sdio_o    = dac_pins.sdo;
  assign dac_sdio_oe_o = dac_pins.sdo_oe;
  assign dac_rst_o     = soft_rst;

endmodule

`default_nettype wire

// ==== tb/tb_demod_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_demod_top;

  localparam int CYCLE_LIMIT = 4000;  // about four times the test length
  localparam int STRETCH     = 6;     // soft reset length

  logic        ck933;
  logic        clockCounterEn;
  logic        ncs;
  logic        nwe;
  logic        nrd;
  logic [11:1] addr;
  logic [15:0] wdata;
  logic [15:0] rdata;
  logic        data_oe;
  logic        sdio_in;
  logic        sdio_out;
  logic        sdio_oe;
  logic        dac_sclk;
  logic [2:0]  dac_ncs;
  logic        dac_rst;

  integer      seed = 17598;
  int          cycles = 0;
  int          test_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       cur_test = "reset";
  logic        cap_bits[$];
  logic        cap_oe[$];
  logic [2:0]  cap_ncs[$];
  logic [7:0]  rd_byte = 8'h00;  // byte the dac answers with
  int          rd_cnt = 0;
  logic        sclk_prev = 1'b0;
  int          rst_run = 0;
  int          rst_len = 0;

  demod_top uut (
    .ck933          (ck933),
    .clockCounterEn (clockCounterEn),
    .ncs_i          (ncs),
    .nwe_i          (nwe),
    .nrd_i          (nrd),
    .addr_i         (addr),
    .data_i         (wdata),
    .data_o         (rdata),
    .data_oe_o      (data_oe),
    .dac_sdio_i     (sdio_in),
    .dac_sdio_o     (sdio_out),
    .dac_sdio_oe_o  (sdio_oe),
    .dac_sclk_o     (dac_sclk),
    .dac_ncs_o      (dac_ncs),
    .dac_rst_o      (dac_rst)
  );

  initial begin
    ck933 = 1'b0;
    forever #2 ck933 = ~ck933;
  end

  always @(posedge ck933) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run stopped after %0d cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // ********************
  // dac model and reset monitor
  // ********************
  always @(negedge ck933) begin
    if (dac_sclk && !sclk_prev && !(&dac_ncs)) begin  // rising sclk seen
      cap_bits.push_back(sdio_out);
      cap_oe.push_back(sdio_oe);
      cap_ncs.push_back(dac_ncs);
      if (!sdio_oe) rd_cnt++;
    end
    sclk_prev = dac_sclk;
    sdio_in = (rd_cnt < 8) ? rd_byte[7 - rd_cnt] : 1'b0;  // msb first
    if (dac_rst) begin
      rst_run++;
    end else if (rst_run != 0) begin
      rst_len = rst_run;
      rst_run = 0;
    end
  end

  sclk_needs_cs_a: assert property (@(posedge ck933) disable iff (clockCounterEn)
    (&dac_ncs) |-> !dac_sclk)
    else begin
      $display("error %s: sclk high with no chip select low", cur_test);
      test_errs++;
    end

  task automatic check_eq(input string what, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", cur_test, test_errs);
    end
    test_errs = 0;
  endtask

  // ********************
  // bus access
  // ********************
  task automatic bus_write(input logic [11:0] a, input logic [15:0] d);
    @(negedge ck933);
    addr = a[11:1];
    wdata = d;
    ncs = 1'b0;
    @(negedge ck933);
    nwe = 1'b0;
    repeat (5) @(negedge ck933);
    nwe = 1'b1;
    repeat (4) @(negedge ck933);  // cs still low when the synced nwe edge lands
    ncs = 1'b1;
    repeat (3) @(negedge ck933);
  endtask

  task automatic bus_read(input logic [11:0] a, output logic [15:0] d);
    @(negedge ck933);
    addr = a[11:1];
    ncs = 1'b0;
    @(negedge ck933);
    nrd = 1'b0;
    repeat (6) @(negedge ck933);
    d = rdata;
    check_eq("data_oe", 16'h0001, {15'h0000, data_oe});
    nrd = 1'b1;
    @(negedge ck933);
    ncs = 1'b1;
    repeat (3) @(negedge ck933);
  endtask

  task automatic measure_clock(input int n);
    logic [15:0] lo;
    logic [15:0] hi;
    int          val;
    bus_write(12'h008, 16'h0000);  // restart
    repeat (n) @(negedge ck933);
    bus_read(12'h008, lo);
    bus_read(12'h00A, hi);
    val = {hi, lo};
    assert (val >= n && val <= n + 20) else begin
      $display("error %s: expected %0d to %0d, actual %0d", cur_test, n, n + 20, val);
      test_errs++;
    end
  endtask

  task automatic dac_transfer(input logic [1:0] num, input logic rd, input logic [15:0] frame);
    logic [15:0] st;
    logic [15:0] got_bits;
    logic [15:0] got_oe;
    logic [2:0]  exp_ncs;
    cap_bits.delete();
    cap_oe.delete();
    cap_ncs.delete();
    rd_cnt = 0;
    exp_ncs = ~(3'b001 << num);
    got_bits = '0;
    got_oe = '0;
    bus_write(12'h102, frame);
    bus_write(12'h100, {13'h0000, rd, num});
    bus_read(12'h104, st);
    check_eq("status busy", 16'h0001, st);
    while (st[0]) bus_read(12'h104, st);  // poll until idle
    check_eq("bit count", 16'd16, 16'(cap_bits.size()));
    foreach (cap_bits[i]) begin
      got_bits = {got_bits[14:0], cap_bits[i]};
      got_oe = {got_oe[14:0], cap_oe[i]};
      check_eq("chip select", {13'h0000, exp_ncs}, {13'h0000, cap_ncs[i]});
    end
    if (rd) begin
      check_eq("instruction", {8'h00, frame[15:8]}, {8'h00, got_bits[15:8]});
      check_eq("sdo_oe", 16'hFF00, got_oe);
    end else begin
      check_eq("frame", frame, got_bits);
      check_eq("sdo_oe", 16'hFFFF, got_oe);
    end
  endtask

  // ********************
  // test sequence
  // ********************
  initial begin
    logic [15:0] rd;
    logic [15:0] frame;
    clockCounterEn = 1'b1;
    ncs = 1'b1;
    nwe = 1'b1;
    nrd = 1'b1;
    addr = '0;
    wdata = '0;
    sdio_in = 1'b0;
    repeat (10) @(negedge ck933);
    clockCounterEn = 1'b0;
    @(negedge ck933);
    check_eq("sclk oe rst data_oe ncs", 16'h0007,
             {9'h000, dac_sclk, sdio_oe, dac_rst, data_oe, dac_ncs});
    finish_test();

    cur_test = "version";
    bus_read(12'h006, rd);
    check_eq("upper half", 16'h0056, rd);
    bus_read(12'h004, rd);
    check_eq("lower half", 16'h0000, rd);
    bus_read(12'h206, rd);
    check_eq("unmapped 2", 16'h0000, rd);
    bus_read(12'hF04, rd);
    check_eq("unmapped f", 16'h0000, rd);
    finish_test();

    cur_test = "clock_measure";
    measure_clock(200);
    measure_clock(500);
    finish_test();

    cur_test = "soft_reset";
    rst_len = 0;
    bus_write(12'h102, 16'hA5A5);
    bus_write(12'h100, 16'h0001);
    repeat (8) @(negedge ck933);  // transfer is running
    check_eq("running ncs", 16'h0005, {13'h0000, dac_ncs});
    bus_read(12'h000, rd);
    while (rst_len == 0) @(negedge ck933);
    check_eq("reset length", 16'(STRETCH), 16'(rst_len));
    check_eq("sclk oe ncs", 16'h0007, {11'h000, dac_sclk, sdio_oe, dac_ncs});
    bus_read(12'h104, rd);
    check_eq("status idle", 16'h0000, rd);
    finish_test();

    cur_test = "dac_write";
    for (int n = 0; n < 3; n++) begin
      frame = 16'($random(seed));
      dac_transfer(2'(n), 1'b0, frame);
    end
    finish_test();

    cur_test = "dac_read";
    rd_byte = 8'($random(seed));
    frame = 16'($random(seed));
    dac_transfer(2'd2, 1'b1, frame);
    bus_read(12'h106, rd);
    check_eq("read back", {8'h00, rd_byte}, rd);
    finish_test();

    $display("%0d tests, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/demod_pkg.sv
verilog/host_bus.sv
verilog/misc_regs.sv
verilog/dac_spi_master.sv
verilog/demod_top.sv
tb/tb_demod_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_demod_top -f build.f -o sim_tb || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -qx "Regression passed" && echo "PASS" || { echo "FAIL"; exit 1; }
